//--- Makefile
# Verilator build and run of the memory stage testbench

VERILATOR ?= verilator
TOP       ?= mem_stage_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HEADERS := $(wildcard hdl/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- hdl/bus_pkg.sv
// types for the word bus between the lsu and the targets behind it
package bus_pkg;

  // word request shared by every target on the bus
  // each target also gets its own select level from the lsu
  typedef struct packed
  {
    // a target writes only when this and its select are both high
    logic        wr_en;
    // byte address with the two lane bits removed
    logic [29:0] word_addr;
    // one enable per byte lane, bit 0 is the lowest byte
    logic [3:0]  be;
    // store data already replicated into every lane it may land in
    logic [31:0] wdata;
  } bus_req_t;

  // read word that a target returns without waiting for a clock
  // the lsu picks one of these by the select it raised
  typedef logic [31:0] bus_word_t;

endpackage

//--- hdl/data_mem.sv
`include "mem_consts.svh"

// word-organized data memory
// the read port is combinational and the write port is clocked
module data_mem
  import bus_pkg::*;
(
  input  logic      CLK,
  input  bus_req_t  req,
  input  logic      sel,
  output bus_word_t rdata
);

  localparam int IDX_W = $clog2(`DMEM_WORDS);

  logic [31:0]      mem_cell [`DMEM_WORDS];
  logic [IDX_W-1:0] idx;

  // only the low word address bits index the array
  // the lsu has already confirmed the access falls inside the memory
  assign idx = req.word_addr[IDX_W-1:0];

  // each enabled lane is written on its own so byte and half stores merge
  // with the lanes around them
  always_ff @(posedge CLK)
  begin
    if (sel && req.wr_en)
    begin
      for (int lane = 0; lane < 4; lane++)
      begin
        if (req.be[lane])
        begin
          mem_cell[idx][8*lane +: 8] <= req.wdata[8*lane +: 8];
        end
      end
    end
  end

  // the read follows the address at all times
  // a store written at this edge shows up here in the next cycle
  assign rdata = mem_cell[idx];

endmodule

//--- hdl/io_regs.sv
`include "mem_consts.svh"

// memory-mapped I/O block with one output register and one input port
module io_regs
  import bus_pkg::*;
(
  input  logic        CLK,
  input  logic        arst_n,
  input  bus_req_t    req,
  input  logic        sel,
  input  logic [31:0] gpio_in,
  output logic [31:0] gpio_out,
  output bus_word_t   rdata
);

  localparam int OFS_W = $clog2(`IO_WORDS);

  logic [OFS_W-1:0] ofs;
  logic             out_hit;
  logic             in_hit;

  // the I/O base is aligned to the region size so the low bits are the offset
  assign ofs     = req.word_addr[OFS_W-1:0];
  assign out_hit = ofs == OFS_W'(`IO_OUT_OFS);
  assign in_hit  = ofs == OFS_W'(`IO_IN_OFS);

  // only the output register takes writes
  // writes to the input port or to spare offsets are dropped
  always_ff @(posedge CLK or negedge arst_n)
  begin
    if (!arst_n)
    begin
      gpio_out <= '0;
    end
    else if (sel && req.wr_en && out_hit)
    begin
      for (int lane = 0; lane < 4; lane++)
      begin
        if (req.be[lane])
        begin
          gpio_out[8*lane +: 8] <= req.wdata[8*lane +: 8];
        end
      end
    end
  end

  // the input port is passed through in the same cycle
  // offsets with nothing behind them read as zero
  assign rdata = out_hit ? gpio_out : (in_hit ? gpio_in : '0);

endmodule

//--- hdl/isa_pkg.sv
// types for memory operations as the processor core issues them
package isa_pkg;

  // width of one access as given by the load or store instruction
  // the fourth encoding is not used and is reported as a fault by the lsu
  typedef enum logic [1:0]
  {
    MEM_BYTE = 2'b00,
    MEM_HALF = 2'b01,
    MEM_WORD = 2'b10
  } mem_size_t;

  // one access from the execute stage, valid in the cycle it is presented
  // rd_en and wr_en are plain strobes with no handshake behind them
  typedef struct packed
  {
    logic        rd_en;
    logic        wr_en;
    // access width, which decides alignment and the lanes touched
    mem_size_t   size;
    // high for lbu and lhu, so the loaded part is zero-extended
    logic        is_unsigned;
    // byte address as computed by the core
    logic [31:0] addr;
    // store data sits in the low bits for byte and half stores
    logic [31:0] wdata;
  } mem_op_t;

endpackage

//--- hdl/lsu.sv
`include "mem_consts.svh"

// load/store unit between the core's access and the word bus
// everything here settles in the cycle the access is presented
module lsu
  import isa_pkg::*;
  import bus_pkg::*;
(
  input  mem_op_t     op,
  input  bus_word_t   dmem_rdata,
  input  bus_word_t   io_rdata,
  output bus_req_t    req,
  output logic        dmem_sel,
  output logic        io_sel,
  output logic [31:0] rdata,
  output logic        fault
);

  logic        access;
  logic [1:0]  byte_ofs;
  logic        misaligned;
  logic [31:0] dmem_ofs;
  logic [31:0] io_ofs;
  logic        in_dmem;
  logic        in_io;
  logic [3:0]  lane_be;
  logic [31:0] lane_wdata;
  bus_word_t   sel_word;
  logic [31:0] shifted;

  // an idle cycle has neither strobe and never faults
  assign access   = op.rd_en | op.wr_en;
  assign byte_ofs = op.addr[1:0];

  // region checks are done on the offset from each base so a base of zero needs no
  // lower bound, and wrap-around below a base lands far out of range
  assign dmem_ofs = op.addr - `DMEM_BASE;
  assign io_ofs   = op.addr - `IO_BASE;
  assign in_dmem  = dmem_ofs < `DMEM_BYTES;
  assign in_io    = io_ofs < `IO_BYTES;

  // alignment, lane enables and store data all follow from the size
  always_comb
  begin
    misaligned = 1'b0;
    lane_be    = 4'b1111;
    lane_wdata = op.wdata;
    case (op.size)
      MEM_BYTE:
      begin
        lane_be    = 4'b0001 << byte_ofs;
        lane_wdata = {4{op.wdata[7:0]}};
      end
      MEM_HALF:
      begin
        misaligned = byte_ofs[0];
        lane_be    = 4'b0011 << byte_ofs;
        lane_wdata = {2{op.wdata[15:0]}};
      end
      MEM_WORD:
      begin
        misaligned = |byte_ofs;
      end
      default:
      begin
        // the spare size encoding is treated like a bad address
        misaligned = 1'b1;
      end
    endcase
  end

  // a faulting access selects nothing, so no target can change state
  assign fault    = access & (misaligned | ~(in_dmem | in_io));
  assign dmem_sel = access & ~misaligned & in_dmem;
  assign io_sel   = access & ~misaligned & in_io;

  // the request goes to both targets and only the selected one acts on it
  always_comb
  begin
    req.wr_en     = op.wr_en;
    req.word_addr = op.addr[31:2];
    req.be        = lane_be;
    req.wdata     = lane_wdata;
  end

  // an unselected access reads as an all-zero word
  assign sel_word = dmem_sel ? dmem_rdata : (io_sel ? io_rdata : '0);

  // move the addressed lanes down to bit 0
  assign shifted = sel_word >> {byte_ofs, 3'b000};

  always_comb
  begin
    case (op.size)
      MEM_BYTE:
      begin
        rdata = op.is_unsigned ? {24'b0, shifted[7:0]} : {{24{shifted[7]}}, shifted[7:0]};
      end
      MEM_HALF:
      begin
        rdata = op.is_unsigned ? {16'b0, shifted[15:0]} : {{16{shifted[15]}}, shifted[15:0]};
      end
      default:
      begin
        rdata = shifted;
      end
    endcase
    // stores and idle cycles return zero even when a target is selected
    if (!op.rd_en)
    begin
      rdata = '0;
    end
  end

endmodule

//--- hdl/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// depth of the data memory in 32-bit words
`define DMEM_WORDS 1024
// byte address where the data memory starts
`define DMEM_BASE  32'h0000_0000
// size of the data memory region in bytes
`define DMEM_BYTES (`DMEM_WORDS * 4)

// byte address of the I/O region
`define IO_BASE    32'h0001_0000
// the I/O region spans this many words, most of them read as zero
`define IO_WORDS   16
`define IO_BYTES   (`IO_WORDS * 4)

// word offsets inside the I/O region
`define IO_OUT_OFS 0
`define IO_IN_OFS  1

`endif

//--- hdl/mem_stage.sv
// memory stage of the load/store processor
// the lsu checks each access and routes it to the data memory or to the I/O block
module mem_stage
  import isa_pkg::*;
  import bus_pkg::*;
(
  input  logic        CLK,
  input  logic        arst_n,
  input  mem_op_t     op,
  input  logic [31:0] gpio_in,
  output logic [31:0] rdata,
  output logic        fault,
  output logic [31:0] gpio_out
);

  // one request fans out to both targets
  bus_req_t  req;
  // at most one of these is high in any cycle
  logic      dmem_sel;
  logic      io_sel;
  // both read words come back combinationally
  bus_word_t dmem_rdata;
  bus_word_t io_rdata;

  // alignment, address decode, lane enables and load extension
  lsu lsu_i
  (
    .op         (op),
    .dmem_rdata (dmem_rdata),
    .io_rdata   (io_rdata),
    .req        (req),
    .dmem_sel   (dmem_sel),
    .io_sel     (io_sel),
    .rdata      (rdata),
    .fault      (fault)
  );

  // data memory has no reset so its contents start undefined
  data_mem data_mem_i
  (
    .CLK   (CLK),
    .req   (req),
    .sel   (dmem_sel),
    .rdata (dmem_rdata)
  );

  // output register and input port
  io_regs io_regs_i
  (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .req      (req),
    .sel      (io_sel),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .rdata    (io_rdata)
  );

endmodule

//--- sim/mem_stage_properties.sv
// assertions on the ports of the memory stage
module mem_stage_properties
  import isa_pkg::*;
(
  input logic        CLK,
  input logic        arst_n,
  input mem_op_t     op,
  input logic [31:0] rdata,
  input logic        fault,
  input logic [31:0] gpio_out
);

  timeunit 1ns;
  timeprecision 100ps;

  // a rejected store selects no target, so the output register holds its value
  faulting_store_keeps_gpio: assert property
  (
    @(posedge CLK) disable iff (!arst_n)
    (fault && op.wr_en) |=> $stable(gpio_out)
  )
  else $error("gpio_out changed after a faulting store");

  // a faulting access never returns data
  fault_reads_zero: assert property
  (
    @(posedge CLK) disable iff (!arst_n)
    fault |-> (rdata == '0)
  )
  else $error("rdata is not zero during a faulting access");

  // stores and idle cycles return zero as well
  no_read_reads_zero: assert property
  (
    @(posedge CLK) disable iff (!arst_n)
    !op.rd_en |-> (rdata == '0)
  )
  else $error("rdata is not zero without a read strobe");

  // the first edge after reset release still sees the cleared register
  gpio_clear_after_reset: assert property
  (
    @(posedge CLK)
    $rose(arst_n) |-> (gpio_out == '0)
  )
  else $error("gpio_out is not zero after reset");

endmodule

bind mem_stage mem_stage_properties props_i
(
  .CLK      (CLK),
  .arst_n   (arst_n),
  .op       (op),
  .rdata    (rdata),
  .fault    (fault),
  .gpio_out (gpio_out)
);

//--- sim/mem_stage_tb.sv
// testbench for the memory stage
// each line of the test data file is one access with its expected results
module mem_stage_tb
  import isa_pkg::*;
  import bus_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int    RESET_CYCLES     = 8;
  localparam int    RESET_WAIT_LIMIT = 64;
  localparam string DATA_FILE        = "sim/mem_stage_testdata.txt";

  logic        CLK;
  logic        arst_n;
  mem_op_t     op;
  logic [31:0] gpio_in;
  logic [31:0] rdata;
  logic        fault;
  logic [31:0] gpio_out;

  mem_stage dut_i
  (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .op       (op),
    .gpio_in  (gpio_in),
    .rdata    (rdata),
    .fault    (fault),
    .gpio_out (gpio_out)
  );

  // 4 ns clock period
  initial
  begin
    CLK = 1'b0;
  end

  always #2 CLK = ~CLK;

  // reset is held for a fixed number of cycles and released just after an edge
  initial
  begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1 arst_n = 1'b1;
  end

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped after the first failure");
  endtask

  task automatic report_mismatch(string what);
    $display("Error at time %0d ns: %s", $time, what);
    abort_run();
  endtask

  // the load result as returned on the stage's rdata port
  task automatic check_word(bus_word_t got, bus_word_t exp, string what);
    if (got !== exp)
    begin
      report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    end
  endtask

  task automatic check_fault(logic got, logic exp, string what);
    if (got !== exp)
    begin
      report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    end
  endtask

  // the output register as seen on the gpio_out pins
  task automatic check_gpio(logic [31:0] got, logic [31:0] exp, string what);
    if (got !== exp)
    begin
      report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    end
  endtask

  initial
  begin
    int        fd;
    int        fields;
    int        line_no;
    int        accesses;
    int        wait_cycles;
    string     line;
    bit [31:0] col [10];
    mem_op_t   next_op;
    bus_word_t expected;

    void'($urandom(60533));
    op          = '0;
    gpio_in     = '0;
    line_no     = 0;
    accesses    = 0;
    wait_cycles = 0;

    fd = $fopen(DATA_FILE, "r");
    if (fd == 0)
    begin
      $display("the test data file %s could not be opened", DATA_FILE);
      abort_run();
    end

    // poll the reset level at falling edges, away from the release point
    while (arst_n !== 1'b1)
    begin
      if (wait_cycles >= RESET_WAIT_LIMIT)
      begin
        $display("reset was still active after %0d cycles", RESET_WAIT_LIMIT);
        abort_run();
      end
      else
      begin
        @(negedge CLK);
        wait_cycles++;
      end
    end
    check_gpio(gpio_out, '0, "gpio_out after reset");

    // accesses start 1 ns after a rising edge
    @(posedge CLK);
    #1;

    while ($fgets(line, fd) != 0)
    begin
      line_no++;
      fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", col[0], col[1], col[2],
                       col[3], col[4], col[5], col[6], col[7], col[8], col[9]);
      // comment lines and blank lines hold no access
      if (line.getc(0) == "#" || fields <= 0)
      begin
        continue;
      end
      if (fields != 10)
      begin
        $display("line %0d of %s does not hold ten fields", line_no, DATA_FILE);
        abort_run();
      end

      next_op.rd_en       = col[1][0];
      next_op.wr_en       = col[2][0];
      next_op.size        = mem_size_t'(col[3][1:0]);
      next_op.is_unsigned = col[4][0];
      next_op.addr        = col[5];
      next_op.wdata       = col[6];
      op                  = next_op;
      gpio_in             = $urandom();

      // kind 1 is a word load of the input port, which returns the pins as driven now
      expected = (col[0] == 32'd1) ? gpio_in : col[7];

      // rdata and fault are combinational, so they are settled well before the edge
      #2;
      check_fault(fault, col[8][0], $sformatf("line %0d fault", line_no));
      check_word(rdata, expected, $sformatf("line %0d rdata", line_no));

      // a write lands at the edge and gpio_out is checked just after it
      @(posedge CLK);
      #1;
      check_gpio(gpio_out, col[9], $sformatf("line %0d gpio_out", line_no));
      accesses++;
    end
    $fclose(fd);
    op = '0;

    if (accesses == 0)
    begin
      $display("no accesses were found in %s", DATA_FILE);
      abort_run();
    end
    else
    begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

//--- sim/mem_stage_testdata.txt
# kind rd_en wr_en size is_unsigned addr wdata exp_rdata exp_fault exp_gpio, all in hex
# size 0 byte, 1 half, 2 word; kind 1 expects the gpio_in value driven with the load
0 0 1 2 0 00000000 12345678 00000000 0 00000000
0 0 1 2 0 00000004 deadbeef 00000000 0 00000000
0 0 1 2 0 00000ffc cafef00d 00000000 0 00000000
0 1 0 2 0 00000000 00000000 12345678 0 00000000
0 1 0 2 0 00000004 00000000 deadbeef 0 00000000
0 1 0 2 0 00000ffc 00000000 cafef00d 0 00000000
# byte and half stores merged into the word at 0x100
0 0 1 2 0 00000100 00000000 00000000 0 00000000
0 0 1 0 0 00000100 123456a5 00000000 0 00000000
0 0 1 0 0 00000101 0000007f 00000000 0 00000000
0 0 1 1 0 00000102 ffff80f0 00000000 0 00000000
0 1 0 2 0 00000100 00000000 80f07fa5 0 00000000
0 1 0 0 0 00000100 00000000 ffffffa5 0 00000000
0 1 0 0 1 00000100 00000000 000000a5 0 00000000
0 1 0 0 0 00000101 00000000 0000007f 0 00000000
0 1 0 0 0 00000102 00000000 fffffff0 0 00000000
0 1 0 0 1 00000103 00000000 00000080 0 00000000
0 1 0 0 0 00000103 00000000 ffffff80 0 00000000
0 1 0 1 0 00000100 00000000 00007fa5 0 00000000
0 1 0 1 0 00000102 00000000 ffff80f0 0 00000000
0 1 0 1 1 00000102 00000000 000080f0 0 00000000
# misaligned accesses around the word at 0x200
0 0 1 2 0 00000200 55aa55aa 00000000 0 00000000
0 0 1 2 0 00000202 11111111 00000000 1 00000000
0 0 1 1 0 00000201 00002222 00000000 1 00000000
0 1 0 2 0 00000201 00000000 00000000 1 00000000
0 1 0 1 0 00000203 00000000 00000000 1 00000000
0 1 0 2 0 00000200 00000000 55aa55aa 0 00000000
# unmapped addresses
0 1 0 2 0 00001000 00000000 00000000 1 00000000
0 0 1 2 0 00020000 ffffffff 00000000 1 00000000
0 1 0 2 0 00010040 00000000 00000000 1 00000000
0 1 0 2 0 fffffffc 00000000 00000000 1 00000000
# output register, input port and spare I/O offsets
0 0 1 2 0 00010000 11223344 00000000 0 11223344
0 0 1 0 0 00010002 000000ab 00000000 0 11ab3344
0 1 0 2 0 00010000 00000000 11ab3344 0 11ab3344
1 1 0 2 0 00010004 00000000 00000000 0 11ab3344
0 1 0 2 0 00010008 00000000 00000000 0 11ab3344
0 1 0 2 0 0001003c 00000000 00000000 0 11ab3344
0 0 1 2 0 00010004 ffffffff 00000000 0 11ab3344
0 0 1 2 0 00010008 ffffffff 00000000 0 11ab3344
0 0 1 2 0 00010001 ffffffff 00000000 1 11ab3344
0 1 0 0 1 00010003 00000000 00000011 0 11ab3344
0 1 0 0 0 00010002 00000000 ffffffab 0 11ab3344
0 0 1 1 0 00010000 0000beef 00000000 0 11abbeef
0 1 0 2 0 00010000 00000000 11abbeef 0 11abbeef
1 1 0 2 0 00010004 00000000 00000000 0 11abbeef

//--- vlog.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/bus_pkg.sv
hdl/lsu.sv
hdl/data_mem.sv
hdl/io_regs.sv
hdl/mem_stage.sv
sim/mem_stage_properties.sv
sim/mem_stage_tb.sv
